//--- src/rvci_pkg.sv
`default_nettype none

package rvci_pkg;

    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [4:0]  reg_idx_t;  // Register index
    typedef logic [3:0]  wstrb_t;    // Byte lane strobe

    // Reset fetch address and instruction size
    localparam word_t RESET_BOOT_ADDR = 32'h0000_1000;
    localparam word_t INSTR_BYTES     = 32'd4;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [3:0] {
        KIND_ALU,
        KIND_LOAD,
        KIND_STORE,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_LUI,
        KIND_AUIPC,
        KIND_NOP
    } op_kind_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_RESULT
    } fetch_state_e;

endpackage

`default_nettype wire

//--- src/rvci_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded operation, decode to execute
interface rvci_dec_if import rvci_pkg::*; ();
    logic        valid;   // One cycle strobe
    op_kind_e    kind;
    alu_op_e     alu_op;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       imm;
    reg_idx_t    rd;
    word_t       pc;
    logic [2:0]  funct3;  // Branch condition or access width

    modport source (output valid, kind, alu_op, rs1_val, rs2_val, imm, rd, pc, funct3);
    modport sink   (input  valid, kind, alu_op, rs1_val, rs2_val, imm, rd, pc, funct3);
endinterface

// Executed result, execute to result stage
interface rvci_exe_if import rvci_pkg::*; ();
    logic        valid;
    op_kind_e    kind;
    logic [2:0]  funct3;
    word_t       value;       // ALU result or link address
    word_t       addr;
    word_t       store_data;
    reg_idx_t    rd;
    word_t       next_pc;

    modport source (output valid, kind, funct3, value, addr, store_data, rd, next_pc);
    modport sink   (input  valid, kind, funct3, value, addr, store_data, rd, next_pc);
endinterface

`default_nettype wire

//--- src/rvci_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rvci_fetch import rvci_pkg::*; #(
    parameter word_t BOOT_ADDR = RESET_BOOT_ADDR
) (
    input  logic  sys_clk,
    input  logic  rst_n_i,

    output logic  ibus_cyc_o,
    output logic  ibus_stb_o,
    output word_t ibus_addr_o,
    input  word_t ibus_data_i,
    input  logic  ibus_ack_i,

    output word_t instr_o,
    output logic  instr_valid_o,

    input  logic  retire_i,
    input  word_t next_pc_i
);

    fetch_state_e state;
    word_t        pc;

    // Bus request is simply the fetch state
    assign ibus_cyc_o  = (state == ST_FETCH);
    assign ibus_stb_o  = (state == ST_FETCH);
    assign ibus_addr_o = pc;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state         <= ST_IDLE;
            pc            <= BOOT_ADDR;
            instr_valid_o <= 1'b0;
        end else begin
            instr_valid_o <= 1'b0;
            case (state)
                ST_IDLE:    state <= ST_FETCH;
                ST_FETCH: begin
                    if (ibus_ack_i) begin
                        instr_valid_o <= 1'b1;  // Decode sees it next cycle
                        state         <= ST_DECODE;
                    end
                end
                ST_DECODE:  state <= ST_EXECUTE;
                ST_EXECUTE: state <= ST_RESULT;
                ST_RESULT: begin
                    // Wait here for loads and stores to finish
                    if (retire_i) begin
                        pc    <= next_pc_i;
                        state <= ST_FETCH;
                    end
                end
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (ibus_cyc_o && ibus_ack_i) begin
            instr_o <= ibus_data_i;
        end
    end

    a_ibus_addr_stable: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        (ibus_stb_o && !ibus_ack_i) |=> $stable(ibus_addr_o));

endmodule

`default_nettype wire

//--- src/rvci_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rvci_regfile import rvci_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n_i,

    input  reg_idx_t rd_idx_a_i,
    input  reg_idx_t rd_idx_b_i,
    output word_t    rd_val_a_o,
    output word_t    rd_val_b_o,

    input  logic     wr_en_i,
    input  reg_idx_t wr_idx_i,
    input  word_t    wr_data_i
);

    word_t regs [31:1];  // No storage for x0

    assign rd_val_a_o = (rd_idx_a_i == '0) ? '0 : regs[rd_idx_a_i];
    assign rd_val_b_o = (rd_idx_b_i == '0) ? '0 : regs[rd_idx_b_i];

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != '0)) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

//--- src/rvci_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rvci_decode import rvci_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n_i,

    input  word_t    instr_i,
    input  logic     instr_valid_i,
    input  word_t    pc_i,

    output reg_idx_t rf_idx_a_o,
    output reg_idx_t rf_idx_b_o,
    input  word_t    rf_val_a_i,
    input  word_t    rf_val_b_i,

    rvci_dec_if.source dec
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;       // funct7 bit 5, picks SUB and SRA
    op_kind_e   kind;
    alu_op_e    alu_op;
    word_t      imm;

    assign opcode     = opcode_e'(instr_i[6:0]);
    assign funct3     = instr_i[14:12];
    assign alt        = instr_i[30];
    assign rf_idx_a_o = instr_i[19:15];
    assign rf_idx_b_o = instr_i[24:20];

    always_comb begin
        kind = KIND_NOP;
        imm  = '0;
        case (opcode)
            OPC_LUI:    begin kind = KIND_LUI;    imm = {instr_i[31:12], 12'b0}; end
            OPC_AUIPC:  begin kind = KIND_AUIPC;  imm = {instr_i[31:12], 12'b0}; end
            OPC_JAL: begin
                kind = KIND_JAL;
                imm  = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};
            end
            OPC_JALR:   begin kind = KIND_JALR;   imm = {{20{instr_i[31]}}, instr_i[31:20]}; end
            OPC_BRANCH: begin
                kind = KIND_BRANCH;
                imm  = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
            end
            OPC_LOAD:   begin kind = KIND_LOAD;   imm = {{20{instr_i[31]}}, instr_i[31:20]}; end
            OPC_STORE: begin
                kind = KIND_STORE;
                imm  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            OPC_OP_IMM: begin kind = KIND_ALU;    imm = {{20{instr_i[31]}}, instr_i[31:20]}; end
            OPC_OP:     begin kind = KIND_ALU;    imm = rf_val_b_i; end  // Operand b rides in imm
            default:    kind = KIND_NOP;  // FENCE, SYSTEM and the rest
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        if (kind != KIND_ALU) begin
            alu_op = ALU_ADD;
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= instr_valid_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (instr_valid_i) begin
            dec.kind    <= kind;
            dec.alu_op  <= alu_op;
            dec.rs1_val <= rf_val_a_i;
            dec.rs2_val <= rf_val_b_i;
            dec.imm     <= imm;
            dec.rd      <= instr_i[11:7];
            dec.pc      <= pc_i;
            dec.funct3  <= funct3;
        end
    end

endmodule

`default_nettype wire

//--- src/rvci_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rvci_execute import rvci_pkg::*; (
    input  logic sys_clk,
    input  logic rst_n_i,

    rvci_dec_if.sink   dec,
    rvci_exe_if.source exe
);

    word_t alu_res;
    word_t seq_pc;
    word_t target;    // pc relative branch or jump target
    word_t rs1_sum;   // rs1 plus imm, for JALR and memory
    logic  taken;
    word_t next_pc;
    word_t value;

    assign seq_pc  = dec.pc + INSTR_BYTES;
    assign target  = dec.pc + dec.imm;
    assign rs1_sum = dec.rs1_val + dec.imm;

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_res = dec.rs1_val - dec.imm;
            ALU_SLL:  alu_res = dec.rs1_val << dec.imm[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(dec.rs1_val) < $signed(dec.imm)};
            ALU_SLTU: alu_res = {31'b0, dec.rs1_val < dec.imm};
            ALU_XOR:  alu_res = dec.rs1_val ^ dec.imm;
            ALU_SRL:  alu_res = dec.rs1_val >> dec.imm[4:0];
            ALU_SRA:  alu_res = $signed(dec.rs1_val) >>> dec.imm[4:0];
            ALU_OR:   alu_res = dec.rs1_val | dec.imm;
            ALU_AND:  alu_res = dec.rs1_val & dec.imm;
            default:  alu_res = dec.rs1_val + dec.imm;
        endcase
    end

    // Branch condition from funct3
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (dec.rs1_val == dec.rs2_val);
            3'b001:  taken = (dec.rs1_val != dec.rs2_val);
            3'b100:  taken = ($signed(dec.rs1_val) < $signed(dec.rs2_val));
            3'b101:  taken = ($signed(dec.rs1_val) >= $signed(dec.rs2_val));
            3'b110:  taken = (dec.rs1_val < dec.rs2_val);
            3'b111:  taken = (dec.rs1_val >= dec.rs2_val);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = seq_pc;
        value   = alu_res;
        case (dec.kind)
            KIND_BRANCH: next_pc = taken ? target : seq_pc;
            KIND_JAL:    begin next_pc = target;                 value = seq_pc; end
            KIND_JALR:   begin next_pc = {rs1_sum[31:1], 1'b0};  value = seq_pc; end
            KIND_LUI:    value = dec.imm;
            KIND_AUIPC:  value = target;
            default:     ;
        endcase
    end

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exe.valid <= 1'b0;
        end else begin
            exe.valid <= dec.valid;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (dec.valid) begin
            exe.kind       <= dec.kind;
            exe.funct3     <= dec.funct3;
            exe.value      <= value;
            exe.addr       <= rs1_sum;
            exe.store_data <= dec.rs2_val;
            exe.rd         <= dec.rd;
            exe.next_pc    <= next_pc;
        end
    end

    a_next_pc_aligned: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        exe.valid |-> (exe.next_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- src/rvci_result.sv
`timescale 1ns/1ps
`default_nettype none

module rvci_result import rvci_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n_i,

    rvci_exe_if.sink exe,

    output logic     dbus_cyc_o,
    output logic     dbus_stb_o,
    output logic     dbus_we_o,
    output wstrb_t   dbus_wstrb_o,
    output word_t    dbus_addr_o,
    output word_t    dbus_data_o,
    input  word_t    dbus_data_i,
    input  logic     dbus_ack_i,

    output logic     rf_wr_en_o,
    output reg_idx_t rf_wr_idx_o,
    output word_t    rf_wr_data_o,

    output logic     retire_o,
    output word_t    next_pc_o
);

    logic       is_mem;
    logic       writes_rd;
    wstrb_t     st_wstrb;
    reg_idx_t   r_rd;
    logic [2:0] r_funct3;
    logic [1:0] r_byte_off;
    word_t      ld_shift;
    word_t      ld_data;

    assign is_mem    = (exe.kind == KIND_LOAD) || (exe.kind == KIND_STORE);
    assign writes_rd = !((exe.kind == KIND_STORE) || (exe.kind == KIND_BRANCH) ||
                         (exe.kind == KIND_NOP));
    assign rf_wr_idx_o = r_rd;

    always_comb begin
        case (exe.funct3[1:0])
            2'b00:   st_wstrb = 4'b0001 << exe.addr[1:0];
            2'b01:   st_wstrb = 4'b0011 << {exe.addr[1], 1'b0};
            default: st_wstrb = 4'b1111;
        endcase
    end

    // Pick the addressed bytes and extend
    assign ld_shift = dbus_data_i >> {r_byte_off, 3'b000};
    always_comb begin
        case (r_funct3)
            3'b000:  ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
            3'b001:  ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
            3'b100:  ld_data = {24'b0, ld_shift[7:0]};
            3'b101:  ld_data = {16'b0, ld_shift[15:0]};
            default: ld_data = dbus_data_i;  // LW
        endcase
    end

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dbus_cyc_o <= 1'b0;
            dbus_stb_o <= 1'b0;
            dbus_we_o  <= 1'b0;
            rf_wr_en_o <= 1'b0;
            retire_o   <= 1'b0;
        end else begin
            rf_wr_en_o <= 1'b0;
            retire_o   <= 1'b0;
            if (dbus_cyc_o) begin
                if (dbus_ack_i) begin
                    dbus_cyc_o <= 1'b0;
                    dbus_stb_o <= 1'b0;
                    dbus_we_o  <= 1'b0;
                    rf_wr_en_o <= !dbus_we_o;  // Only loads write back
                    retire_o   <= 1'b1;
                end
            end else if (exe.valid) begin
                if (is_mem) begin
                    dbus_cyc_o <= 1'b1;
                    dbus_stb_o <= 1'b1;
                    dbus_we_o  <= (exe.kind == KIND_STORE);
                end else begin
                    rf_wr_en_o <= writes_rd;
                    retire_o   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (exe.valid && !dbus_cyc_o) begin
            r_rd         <= exe.rd;
            r_funct3     <= exe.funct3;
            r_byte_off   <= exe.addr[1:0];
            next_pc_o    <= exe.next_pc;
            dbus_addr_o  <= {exe.addr[31:2], 2'b00};
            dbus_wstrb_o <= st_wstrb;
            dbus_data_o  <= exe.store_data << {exe.addr[1:0], 3'b000};
            rf_wr_data_o <= exe.value;
        end else if (dbus_cyc_o && dbus_ack_i) begin
            rf_wr_data_o <= ld_data;
        end
    end

    // Open request keeps stb and its fields until acked
    a_dbus_req_held: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        (dbus_cyc_o && !dbus_ack_i) |=> (dbus_cyc_o && dbus_stb_o &&
            $stable({dbus_addr_o, dbus_we_o, dbus_wstrb_o, dbus_data_o})));

endmodule

`default_nettype wire

//--- src/processorci_top.sv
`timescale 1ns/1ps
`default_nettype none

module processorci_top import rvci_pkg::*; #(
    parameter word_t BOOT_ADDR = RESET_BOOT_ADDR
) (
    input  logic   sys_clk,
    input  logic   rst_n_i,

    // Instruction fetch port
    output logic   core_cyc_o,
    output logic   core_stb_o,
    output logic   core_we_o,
    output wstrb_t core_wstrb_o,
    output word_t  core_addr_o,
    output word_t  core_data_o,
    input  word_t  core_data_i,
    input  logic   core_ack_i,

    // Data port
    output logic   data_mem_cyc_o,
    output logic   data_mem_stb_o,
    output logic   data_mem_we_o,
    output wstrb_t data_mem_wstrb_o,
    output word_t  data_mem_addr_o,
    output word_t  data_mem_data_o,
    input  word_t  data_mem_data_i,
    input  logic   data_mem_ack_i
);

    word_t    instr;
    logic     instr_valid;
    logic     retire;
    word_t    next_pc;
    reg_idx_t rf_idx_a;
    reg_idx_t rf_idx_b;
    word_t    rf_val_a;
    word_t    rf_val_b;
    logic     rf_wr_en;
    reg_idx_t rf_wr_idx;
    word_t    rf_wr_data;

    rvci_dec_if dec_bus ();
    rvci_exe_if exe_bus ();

    assign core_we_o    = 1'b0;  // Fetch never writes
    assign core_wstrb_o = '0;
    assign core_data_o  = '0;

    rvci_fetch #(.BOOT_ADDR(BOOT_ADDR)) u_fetch (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .ibus_cyc_o(core_cyc_o), .ibus_stb_o(core_stb_o), .ibus_addr_o(core_addr_o),
        .ibus_data_i(core_data_i), .ibus_ack_i(core_ack_i),
        .instr_o(instr), .instr_valid_o(instr_valid),
        .retire_i(retire), .next_pc_i(next_pc)
    );

    rvci_regfile u_regfile (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .rd_idx_a_i(rf_idx_a), .rd_idx_b_i(rf_idx_b),
        .rd_val_a_o(rf_val_a), .rd_val_b_o(rf_val_b),
        .wr_en_i(rf_wr_en), .wr_idx_i(rf_wr_idx), .wr_data_i(rf_wr_data)
    );

    // The fetch address is the PC of the instruction in flight
    rvci_decode u_decode (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .instr_i(instr), .instr_valid_i(instr_valid), .pc_i(core_addr_o),
        .rf_idx_a_o(rf_idx_a), .rf_idx_b_o(rf_idx_b),
        .rf_val_a_i(rf_val_a), .rf_val_b_i(rf_val_b),
        .dec(dec_bus.source)
    );

    rvci_execute u_execute (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .dec(dec_bus.sink), .exe(exe_bus.source)
    );

    rvci_result u_result (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .exe(exe_bus.sink),
        .dbus_cyc_o(data_mem_cyc_o), .dbus_stb_o(data_mem_stb_o), .dbus_we_o(data_mem_we_o),
        .dbus_wstrb_o(data_mem_wstrb_o), .dbus_addr_o(data_mem_addr_o),
        .dbus_data_o(data_mem_data_o), .dbus_data_i(data_mem_data_i),
        .dbus_ack_i(data_mem_ack_i),
        .rf_wr_en_o(rf_wr_en), .rf_wr_idx_o(rf_wr_idx), .rf_wr_data_o(rf_wr_data),
        .retire_o(retire), .next_pc_o(next_pc)
    );

endmodule

`default_nettype wire

//--- sim/tb_processorci_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_processorci_top;

    localparam logic [31:0] BOOT_ADDR  = 32'h0000_1000;
    localparam int          MEM_WORDS  = 2048;  // 8 KB, data low and program at 0x1000
    localparam int          CASE_WORDS = 256;
    localparam int          END_LIMIT  = 4000;

    logic        sys_clk;
    logic        rst_n_i         = 1'b0;
    logic        core_cyc_o, core_stb_o, core_we_o;
    logic [3:0]  core_wstrb_o;
    logic [31:0] core_addr_o, core_data_o;
    logic [31:0] core_data_i     = '0;
    logic        core_ack_i      = 1'b0;
    logic        data_mem_cyc_o, data_mem_stb_o, data_mem_we_o;
    logic [3:0]  data_mem_wstrb_o;
    logic [31:0] data_mem_addr_o, data_mem_data_o;
    logic [31:0] data_mem_data_i = '0;
    logic        data_mem_ack_i  = 1'b0;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] case_data [0:CASE_WORDS-1];
    logic [31:0] fetch_q [$];     // Fetch addresses in ack order
    logic [31:0] wr_addr_q [$];
    logic [31:0] wr_data_q [$];
    logic [3:0]  wr_strb_q [$];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [3:0]  exp_strb_q [$];
    logic [31:0] exp_fetch_q [$];

    integer      seed;
    int          i_wait, d_wait;
    logic        i_pend, d_pend;  // Request open and not acked at last falling edge
    logic [31:0] i_addr_s;
    logic [68:0] d_req_s;
    int          mismatches, failures, pos, n_cases;
    logic        aborted;

    processorci_top #(.BOOT_ADDR(BOOT_ADDR)) i_processorci_top (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .core_cyc_o(core_cyc_o), .core_stb_o(core_stb_o), .core_we_o(core_we_o),
        .core_wstrb_o(core_wstrb_o), .core_addr_o(core_addr_o), .core_data_o(core_data_o),
        .core_data_i(core_data_i), .core_ack_i(core_ack_i),
        .data_mem_cyc_o(data_mem_cyc_o), .data_mem_stb_o(data_mem_stb_o),
        .data_mem_we_o(data_mem_we_o), .data_mem_wstrb_o(data_mem_wstrb_o),
        .data_mem_addr_o(data_mem_addr_o), .data_mem_data_o(data_mem_data_o),
        .data_mem_data_i(data_mem_data_i), .data_mem_ack_i(data_mem_ack_i)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] lane_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    // Last acked fetch was the end of the case
    function automatic logic end_fetched(input logic [31:0] end_addr);
        return (fetch_q.size() != 0) && (fetch_q[fetch_q.size() - 1] == end_addr);
    endfunction

    task automatic mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        mismatches++;
    endtask

    task automatic failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        failures++;
    endtask

    task automatic next_word(output logic [31:0] w);
        w = case_data[pos];
        pos++;
    endtask

    // Both bus models, with stability checks on open requests
    always @(negedge sys_clk) begin
        if (!rst_n_i) begin
            core_ack_i     = 1'b0;
            data_mem_ack_i = 1'b0;
            i_pend         = 1'b0;
            d_pend         = 1'b0;
        end else begin
            if (core_stb_o && (core_we_o || core_wstrb_o != '0 || core_data_o != '0))
                mismatch("fetch request with write fields set");
            if (i_pend && (!core_stb_o || core_addr_o != i_addr_s))
                mismatch("fetch request changed before ack");
            if (d_pend && (!data_mem_stb_o || d_req_s != {data_mem_addr_o, data_mem_we_o,
                    data_mem_wstrb_o, data_mem_data_o}))
                mismatch("data request changed before ack");

            if (core_ack_i) begin
                core_ack_i = 1'b0;
            end else if (core_cyc_o && core_stb_o) begin
                if (i_wait == 0) begin
                    core_ack_i  = 1'b1;
                    core_data_i = mem[core_addr_o[12:2]];
                    fetch_q.push_back(core_addr_o);
                end else begin
                    i_wait--;
                end
            end else begin
                i_wait = $random(seed) & 32'h3;
            end

            if (data_mem_ack_i) begin
                data_mem_ack_i = 1'b0;
            end else if (data_mem_cyc_o && data_mem_stb_o) begin
                if (d_wait == 0) begin
                    data_mem_ack_i = 1'b1;
                    if (data_mem_we_o) begin
                        mem[data_mem_addr_o[12:2]] =
                            (mem[data_mem_addr_o[12:2]] & ~lane_mask(data_mem_wstrb_o)) |
                            (data_mem_data_o & lane_mask(data_mem_wstrb_o));
                        wr_addr_q.push_back(data_mem_addr_o);
                        wr_data_q.push_back(data_mem_data_o);
                        wr_strb_q.push_back(data_mem_wstrb_o);
                    end else begin
                        data_mem_data_i = mem[data_mem_addr_o[12:2]];
                    end
                end else begin
                    d_wait--;
                end
            end else begin
                d_wait = $random(seed) & 32'h3;
            end

            i_pend   = core_stb_o && !core_ack_i;
            i_addr_s = core_addr_o;
            d_pend   = data_mem_stb_o && !data_mem_ack_i;
            d_req_s  = {data_mem_addr_o, data_mem_we_o, data_mem_wstrb_o, data_mem_data_o};
        end
    end

    task automatic run_case(input int c);
        logic [31:0] cnt, a, d, s, end_addr;
        int          waited;
        rst_n_i = 1'b0;
        for (int k = 0; k < MEM_WORDS; k++)
            mem[k] = 32'h5A00_0000 ^ (32'(k) << 2);
        next_word(cnt);
        for (int k = 0; k < int'(cnt); k++) begin
            next_word(d);
            mem[BOOT_ADDR[12:2] + k] = d;
        end
        next_word(cnt);
        for (int k = 0; k < int'(cnt); k++) begin
            next_word(a);
            next_word(d);
            mem[a[12:2]] = d;
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_strb_q.delete();
        exp_fetch_q.delete();
        next_word(cnt);
        for (int k = 0; k < int'(cnt); k++) begin
            next_word(a);
            next_word(d);
            next_word(s);
            exp_addr_q.push_back(a);
            exp_data_q.push_back(d);
            exp_strb_q.push_back(s[3:0]);
        end
        next_word(cnt);
        for (int k = 0; k < int'(cnt); k++) begin
            next_word(a);
            exp_fetch_q.push_back(a);
        end
        next_word(end_addr);

        repeat (5) begin
            @(negedge sys_clk);
            if (core_cyc_o || core_stb_o || core_we_o || data_mem_cyc_o || data_mem_stb_o ||
                    data_mem_we_o)
                mismatch("bus active during reset");
        end
        fetch_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_strb_q.delete();
        rst_n_i = 1'b1;

        waited = 0;
        while (!core_cyc_o && waited < 20) begin
            @(negedge sys_clk);
            waited++;
        end
        if (!core_cyc_o) begin
            failure($sformatf("case %0d never started a fetch", c));
            aborted = 1'b1;
            return;
        end
        if (core_addr_o != BOOT_ADDR || waited != 1)
            mismatch($sformatf("case %0d first fetch at %h after %0d cycles", c,
                core_addr_o, waited));

        // The end fetch must be acked so the trace is complete
        waited = 0;
        while (!end_fetched(end_addr) && waited < END_LIMIT) begin
            @(negedge sys_clk);
            waited++;
        end
        if (!end_fetched(end_addr)) begin
            failure($sformatf("case %0d never reached its end address %h", c, end_addr));
            aborted = 1'b1;
            return;
        end

        if (wr_addr_q.size() != exp_addr_q.size())
            mismatch($sformatf("case %0d saw %0d writes, expected %0d", c,
                wr_addr_q.size(), exp_addr_q.size()));
        for (int k = 0; k < wr_addr_q.size() && k < exp_addr_q.size(); k++) begin
            if (wr_addr_q[k] != exp_addr_q[k] || wr_strb_q[k] != exp_strb_q[k] ||
                    ((wr_data_q[k] ^ exp_data_q[k]) & lane_mask(exp_strb_q[k])) != 0)
                mismatch($sformatf("case %0d write %0d got %h/%h/%h expected %h/%h/%h",
                    c, k, wr_addr_q[k], wr_data_q[k], wr_strb_q[k],
                    exp_addr_q[k], exp_data_q[k], exp_strb_q[k]));
        end
        if (fetch_q.size() < exp_fetch_q.size())
            mismatch($sformatf("case %0d fetch trace too short", c));
        for (int k = 0; k < fetch_q.size() && k < exp_fetch_q.size(); k++) begin
            if (fetch_q[k] != exp_fetch_q[k])
                mismatch($sformatf("case %0d fetch %0d at %h expected %h", c, k,
                    fetch_q[k], exp_fetch_q[k]));
        end
    endtask

    initial begin
        seed       = 32'h302f;
        mismatches = 0;
        failures   = 0;
        aborted    = 1'b0;
        i_wait     = 0;
        d_wait     = 0;
        pos        = 0;
        $readmemh("sim/core_cases.txt", case_data);
        n_cases = int'(case_data[0]);
        pos     = 1;
        for (int c = 0; c < n_cases && !aborted; c++)
            run_case(c);
        $display("Done: %0d cases, %0d mismatches, %0d other errors", n_cases,
            mismatches, failures);
        if (mismatches == 0 && failures == 0 && n_cases > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/core_cases.txt
// Case count, then per case: program count and words at 0x1000 | data count, addr data
// | write count, addr data wstrb | fetch trace count, addrs | end (self-jump) address
3
// Arithmetic, logic, LUI, AUIPC
13
00500093 FFD00113 002081B3 40208233 001122B3 00113333 40115393 12345437 00001497
0FF44513 00302023 00402223 00502423 00602623 00702823 00802A23 00902C23 00A02E23
0000006F
0
8
00000000 00000002 F  00000004 00000008 F  00000008 00000001 F  0000000C 00000000 F
00000010 FFFFFFFE F  00000014 12345000 F  00000018 00002020 F  0000001C 123450FF F
0
00001048
// Branches, JAL, JALR, FENCE as no-op
D
00100093 00008463 00009463 00700113 008001EF 00900113 00C18267 00B00113 00302023
00402223 00202423 0FF0000F 0000006F
0
3
00000000 00001014 F  00000004 0000101C F  00000008 00000000 F
A
00001000 00001004 00001008 00001010 00001018 00001020 00001024 00001028 0000102C 00001030
00001030
// Sub-word loads and stores
B
04100083 04304103 04201183 04005203 00102023 00202223 00302423 00402623 021000A3
02301923 0000006F
1
00000040 80F182A3
6
00000000 FFFFFF82 F  00000004 00000080 F  00000008 FFFF80F1 F  0000000C 000082A3 F
00000020 FFFF8200 2  00000030 80F10000 C
0
00001028

//--- build.f
src/rvci_pkg.sv
src/rvci_stage_if.sv
src/rvci_fetch.sv
src/rvci_regfile.sv
src/rvci_decode.sv
src/rvci_execute.sv
src/rvci_result.sv
src/processorci_top.sv
sim/tb_processorci_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_processorci_top -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_processorci_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
